// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cl_ctl_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
hw/cl_ctl_pkg.sv
hw/ddr_stat_pkg.sv
hw/ctl_decode.sv
hw/scrub_walker.sv
hw/id_status_mux.sv
hw/stat_pipe.sv
hw/cl_ctl_top.sv
sim/tb_cl_ctl_top.sv

// File: hw/cl_ctl_pkg.sv
package cl_ctl_pkg;

   // Number of DDR channels with a scrubber
   localparam int NUM_DDR = 4;

   // Channel index used by the decode and readback logic
   typedef logic [1:0] ddr_sel_t;

   // Byte address inside one DDR channel
   typedef logic [63:0] scrb_addr_t;

   // One burst beat on the DDR data bus
   localparam int DDR_BEAT_BYTES = 64;

   // --------------------
   // Shell control word
   // --------------------

   // Bits 3 to 0 are the per-channel scrub enables
   localparam int CTL_DBG_EN_BIT  = 31;
   localparam int CTL_DBG_SEL_LSB = 28;

   // --------------------
   // Identification
   // --------------------

   localparam logic [31:0] CL_SH_ID0_WORD = 32'hF000_1D0F;
   localparam logic [31:0] CL_SH_ID1_WORD = 32'h1D51_FEDC;

   // Channel positions for enable bits and walker indices
   localparam ddr_sel_t DDR_A = 2'd0;
   localparam ddr_sel_t DDR_B = 2'd1;
   localparam ddr_sel_t DDR_D = 2'd2;
   localparam ddr_sel_t DDR_C = 2'd3;

endpackage

// File: hw/cl_ctl_top.sv
module cl_ctl_top
#(
   parameter cl_ctl_pkg::scrb_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                     SCRB_BURST_LEN_MINUS1 = 15,
   parameter int                     STAT_STAGES           = 8
)
(
   input  logic        clk,
   input  logic        sync_rst_n,
   input  logic [31:0] ctl0,
   input  logic        flr_req,
   input  logic [2:0]  ddr_ready,
   input  logic        ddr_c_ready,
   output logic        flr_done,
   output logic [31:0] id0,
   output logic [31:0] id1,
   output logic [3:0]  all_ddr_ready,
   output logic [3:0]  all_scrb_done,

   // Statistics requests from the shell and toward DDR
   input  logic [ddr_stat_pkg::NUM_STAT_CH-1:0] sh_stat_wr,
   input  logic [ddr_stat_pkg::NUM_STAT_CH-1:0] sh_stat_rd,
   input  logic [7:0]                           sh_stat_addr   [ddr_stat_pkg::NUM_STAT_CH],
   input  logic [31:0]                          sh_stat_wdata  [ddr_stat_pkg::NUM_STAT_CH],
   output logic [ddr_stat_pkg::NUM_STAT_CH-1:0] ddr_stat_wr,
   output logic [ddr_stat_pkg::NUM_STAT_CH-1:0] ddr_stat_rd,
   output logic [7:0]                           ddr_stat_addr  [ddr_stat_pkg::NUM_STAT_CH],
   output logic [31:0]                          ddr_stat_wdata [ddr_stat_pkg::NUM_STAT_CH],

   // Statistics acknowledges from DDR and toward the shell
   input  logic [ddr_stat_pkg::NUM_STAT_CH-1:0] ddr_stat_ack,
   input  logic [7:0]                           ddr_stat_int   [ddr_stat_pkg::NUM_STAT_CH],
   input  logic [31:0]                          ddr_stat_rdata [ddr_stat_pkg::NUM_STAT_CH],
   output logic [ddr_stat_pkg::NUM_STAT_CH-1:0] sh_stat_ack,
   output logic [7:0]                           sh_stat_int    [ddr_stat_pkg::NUM_STAT_CH],
   output logic [31:0]                          sh_stat_rdata  [ddr_stat_pkg::NUM_STAT_CH]
);

   import cl_ctl_pkg::*;
   import ddr_stat_pkg::*;

   logic [NUM_DDR-1:0] scrb_en;
   logic               dbg_en;
   logic [2:0]         dbg_sel;
   scrb_addr_t         scrb_addr [NUM_DDR];
   logic [NUM_DDR-1:0] scrb_done;

   // --------------------
   // Control decode
   // --------------------

   ctl_decode u_ctl_decode
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_req    (flr_req),
      .scrb_en    (scrb_en),
      .dbg_en     (dbg_en),
      .dbg_sel    (dbg_sel),
      .flr_done   (flr_done)
   );

   // --------------------
   // Scrub walkers
   // --------------------

   for (genvar ch = 0; ch < NUM_DDR; ch++)
   begin : g_walker
      scrub_walker
      #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      )
      u_scrub_walker
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .scrb_en    (scrb_en[ch]),
         .scrb_addr  (scrb_addr[ch]),
         .scrb_done  (scrb_done[ch])
      );
   end

   // --------------------
   // ID and status
   // --------------------

   id_status_mux u_id_status_mux
   (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .dbg_en        (dbg_en),
      .dbg_sel       (dbg_sel),
      .scrb_addr     (scrb_addr),
      .scrb_done     (scrb_done),
      .ddr_ready     (ddr_ready),
      .ddr_c_ready   (ddr_c_ready),
      .id0           (id0),
      .id1           (id1),
      .all_ddr_ready (all_ddr_ready),
      .all_scrb_done (all_scrb_done)
   );

   // --------------------
   // Statistics pipes
   // --------------------

   for (genvar ch = 0; ch < NUM_STAT_CH; ch++)
   begin : g_stat
      stat_req_t req_in;
      stat_req_t req_out;
      stat_ack_t ack_in;
      stat_ack_t ack_out;

      assign req_in = '{wr: sh_stat_wr[ch], rd: sh_stat_rd[ch],
                        addr: sh_stat_addr[ch], wdata: sh_stat_wdata[ch]};

      assign ddr_stat_wr[ch]    = req_out.wr;
      assign ddr_stat_rd[ch]    = req_out.rd;
      assign ddr_stat_addr[ch]  = req_out.addr;
      assign ddr_stat_wdata[ch] = req_out.wdata;

      assign ack_in = '{ack: ddr_stat_ack[ch], intr: ddr_stat_int[ch],
                        rdata: ddr_stat_rdata[ch]};

      assign sh_stat_ack[ch]   = ack_out.ack;
      assign sh_stat_int[ch]   = ack_out.intr;
      assign sh_stat_rdata[ch] = ack_out.rdata;

      stat_pipe #(.payload_t(stat_req_t), .STAGES(STAT_STAGES)) u_req_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_bus     (req_in),
         .out_bus    (req_out)
      );

      stat_pipe #(.payload_t(stat_ack_t), .STAGES(STAT_STAGES)) u_ack_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_bus     (ack_in),
         .out_bus    (ack_out)
      );
   end

endmodule

// File: hw/ctl_decode.sv
module ctl_decode
(
   input  logic                             clk,
   input  logic                             sync_rst_n,
   input  logic [31:0]                      ctl0,
   input  logic                             flr_req,
   output logic [cl_ctl_pkg::NUM_DDR-1:0]   scrb_en,
   output logic                             dbg_en,
   output logic [2:0]                       dbg_sel,
   output logic                             flr_done
);

   import cl_ctl_pkg::*;

   logic flr_req_q;

   // --------------------
   // Control word
   // --------------------

   // Only the fields in use are kept, the rest of the word is ignored
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrb_en <= '0;
         dbg_en  <= 1'b0;
         dbg_sel <= 3'd0;
      end
      else
      begin
         scrb_en <= ctl0[NUM_DDR-1:0];
         dbg_en  <= ctl0[CTL_DBG_EN_BIT];
         dbg_sel <= ctl0[CTL_DBG_SEL_LSB +: 3];
      end
   end

   // --------------------
   // FLR acknowledge
   // --------------------

   // Pulse once per registered request, a held request toggles the ack
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_req_q <= 1'b0;
         flr_done  <= 1'b0;
      end
      else
      begin
         flr_req_q <= flr_req;
         flr_done  <= flr_req_q && !flr_done;
      end
   end

endmodule

// File: hw/ddr_stat_pkg.sv
package ddr_stat_pkg;

   // DDR controllers with a statistics port
   localparam int NUM_STAT_CH = 3;

   // Shell to DDR request
   typedef struct packed
   {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } stat_req_t;

   // DDR to shell response
   typedef struct packed
   {
      logic        ack;
      logic [7:0]  intr;
      logic [31:0] rdata;
   } stat_ack_t;

endpackage

// File: hw/id_status_mux.sv
module id_status_mux
(
   input  logic                           clk,
   input  logic                           sync_rst_n,
   input  logic                           dbg_en,
   input  logic [2:0]                     dbg_sel,
   input  cl_ctl_pkg::scrb_addr_t         scrb_addr [cl_ctl_pkg::NUM_DDR],
   input  logic [cl_ctl_pkg::NUM_DDR-1:0] scrb_done,
   input  logic [2:0]                     ddr_ready,
   input  logic                           ddr_c_ready,
   output logic [31:0]                    id0,
   output logic [31:0]                    id1,
   output logic [3:0]                     all_ddr_ready,
   output logic [3:0]                     all_scrb_done
);

   import cl_ctl_pkg::*;

   ddr_sel_t   rd_ch;
   scrb_addr_t rd_addr;
   logic       ddr_c_ready_q;

   // --------------------
   // Debug readback
   // --------------------

   always_comb
   begin
      case (dbg_sel)
         3'd3:    rd_ch = DDR_C;
         3'd2:    rd_ch = DDR_D;
         3'd1:    rd_ch = DDR_B;
         default: rd_ch = DDR_A;
      endcase
   end

   assign rd_addr = scrb_addr[rd_ch];

   // ID words, replaced by the walker address while debug is on
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= CL_SH_ID0_WORD;
         id1 <= CL_SH_ID1_WORD;
      end
      else
      begin
         id0 <= dbg_en ? rd_addr[31:0]  : CL_SH_ID0_WORD;
         id1 <= dbg_en ? rd_addr[63:32] : CL_SH_ID1_WORD;
      end
   end

   // --------------------
   // Status vectors
   // --------------------

   // Channel C ready comes from outside the local controller
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_c_ready_q <= 1'b0;
      end
      else
      begin
         ddr_c_ready_q <= ddr_c_ready;
      end
   end

   assign all_ddr_ready = {ddr_ready[2], ddr_c_ready_q, ddr_ready[1:0]};

   assign all_scrb_done = {scrb_done[DDR_C], scrb_done[DDR_D],
                           scrb_done[DDR_B], scrb_done[DDR_A]};

endmodule

// File: hw/scrub_walker.sv
module scrub_walker
#(
   parameter cl_ctl_pkg::scrb_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                     SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  logic                   scrb_en,
   output cl_ctl_pkg::scrb_addr_t scrb_addr,
   output logic                   scrb_done
);

   import cl_ctl_pkg::*;

   // Bytes covered by one burst
   localparam scrb_addr_t BURST_BYTES =
      scrb_addr_t'(DDR_BEAT_BYTES * (SCRB_BURST_LEN_MINUS1 + 1));

   // Start address of the final burst in the range
   localparam scrb_addr_t LAST_BURST = SCRB_MAX_ADDR + scrb_addr_t'(1) - BURST_BYTES;

   logic at_last;

   assign at_last = (scrb_addr == LAST_BURST);

   // One burst per enabled cycle, done is sticky until reset
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrb_addr <= '0;
         scrb_done <= 1'b0;
      end
      else if (scrb_en && !scrb_done)
      begin
         if (at_last)
         begin
            scrb_done <= 1'b1;
         end
         else
         begin
            scrb_addr <= scrb_addr + BURST_BYTES;
         end
      end
   end

endmodule

// File: hw/stat_pipe.sv
module stat_pipe
#(
   parameter type payload_t = logic,
   parameter int  STAGES    = 8
)
(
   input  logic     clk,
   input  logic     sync_rst_n,
   input  payload_t in_bus,
   output payload_t out_bus
);

   payload_t stage_q [STAGES];

   // Plain shift chain, one register per stage
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            stage_q[i] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
         begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule

// File: sim/tb_cl_ctl_top.sv
module tb_cl_ctl_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [63:0] SCRB_MAX_ADDR    = 64'h1FFF;
   localparam int          BURST_LEN_MINUS1 = 15;
   localparam int          STAT_STAGES      = 8;
   localparam logic [63:0] BURST_BYTES      = 64'(64 * (BURST_LEN_MINUS1 + 1));
   localparam logic [63:0] LAST_BURST       = SCRB_MAX_ADDR + 64'd1 - BURST_BYTES;
   localparam logic [31:0] ID0_WORD         = 32'hF000_1D0F;
   localparam logic [31:0] ID1_WORD         = 32'h1D51_FEDC;
   localparam int          ENABLED_CYCLES   = 8;
   localparam int          DONE_TIMEOUT     = 200;

   logic        clk;
   logic        sync_rst_n;
   logic [31:0] ctl0;
   logic        flr_req;
   logic [2:0]  ddr_ready;
   logic        ddr_c_ready;
   logic        flr_done;
   logic [31:0] id0;
   logic [31:0] id1;
   logic [3:0]  all_ddr_ready;
   logic [3:0]  all_scrb_done;
   logic [2:0]  sh_stat_wr;
   logic [2:0]  sh_stat_rd;
   logic [7:0]  sh_stat_addr [3];
   logic [31:0] sh_stat_wdata [3];
   logic [2:0]  ddr_stat_wr;
   logic [2:0]  ddr_stat_rd;
   logic [7:0]  ddr_stat_addr [3];
   logic [31:0] ddr_stat_wdata [3];
   logic [2:0]  ddr_stat_ack;
   logic [7:0]  ddr_stat_int [3];
   logic [31:0] ddr_stat_rdata [3];
   logic [2:0]  sh_stat_ack;
   logic [7:0]  sh_stat_int [3];
   logic [31:0] sh_stat_rdata [3];

   // Reference model state
   logic [3:0]   m_scrb_en;
   logic         m_dbg_en;
   logic [2:0]   m_dbg_sel;
   logic         m_flr_req_q;
   logic         m_flr_done;
   logic [63:0]  m_addr [4];
   logic [3:0]   m_done;
   logic [31:0]  m_id0;
   logic [31:0]  m_id1;
   logic         m_c_ready_q;
   int           en_cnt [4];
   logic [125:0] req_q [$];
   logic [122:0] ack_q [$];

   logic [15:0] lfsr_state;
   string       phase;
   int          errors;
   int          checks;

   cl_ctl_top
   #(
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (BURST_LEN_MINUS1),
      .STAT_STAGES           (STAT_STAGES)
   )
   UUT
   (
      .clk            (clk),
      .sync_rst_n     (sync_rst_n),
      .ctl0           (ctl0),
      .flr_req        (flr_req),
      .ddr_ready      (ddr_ready),
      .ddr_c_ready    (ddr_c_ready),
      .flr_done       (flr_done),
      .id0            (id0),
      .id1            (id1),
      .all_ddr_ready  (all_ddr_ready),
      .all_scrb_done  (all_scrb_done),
      .sh_stat_wr     (sh_stat_wr),
      .sh_stat_rd     (sh_stat_rd),
      .sh_stat_addr   (sh_stat_addr),
      .sh_stat_wdata  (sh_stat_wdata),
      .ddr_stat_wr    (ddr_stat_wr),
      .ddr_stat_rd    (ddr_stat_rd),
      .ddr_stat_addr  (ddr_stat_addr),
      .ddr_stat_wdata (ddr_stat_wdata),
      .ddr_stat_ack   (ddr_stat_ack),
      .ddr_stat_int   (ddr_stat_int),
      .ddr_stat_rdata (ddr_stat_rdata),
      .sh_stat_ack    (sh_stat_ack),
      .sh_stat_int    (sh_stat_int),
      .sh_stat_rdata  (sh_stat_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   // --------------------
   // Random numbers
   // --------------------

   // Galois form of x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Random enables plus a random debug field
   function automatic logic [31:0] scrub_ctl_word();
      logic       dbg;
      logic [2:0] sel;
      logic [3:0] en;
      dbg = rand_bits(1) != 0;
      sel = 3'(rand_bits(3));
      en  = 4'(rand_bits(4));
      return {dbg, sel, 24'h0, en};
   endfunction

   // --------------------
   // Checks
   // --------------------

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("Error in %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      end
   endtask

   task automatic check_outputs();
      check({phase, " flr_done"}, 64'(m_flr_done), 64'(flr_done));
      check({phase, " id0"}, 64'(m_id0), 64'(id0));
      check({phase, " id1"}, 64'(m_id1), 64'(id1));
      check({phase, " all_ddr_ready"},
            64'({ddr_ready[2], m_c_ready_q, ddr_ready[1], ddr_ready[0]}),
            64'(all_ddr_ready));
      // Shell order is C, D, B, A at walker positions 3, 2, 1, 0
      check({phase, " all_scrb_done"},
            64'({m_done[3], m_done[2], m_done[1], m_done[0]}), 64'(all_scrb_done));
      for (int ch = 0; ch < 3; ch++)
      begin
         check($sformatf("%s stat req ch%0d", phase, ch), 64'(req_q[0][ch*42 +: 42]),
               64'({ddr_stat_wr[ch], ddr_stat_rd[ch], ddr_stat_addr[ch],
                    ddr_stat_wdata[ch]}));
         check($sformatf("%s stat ack ch%0d", phase, ch), 64'(ack_q[0][ch*41 +: 41]),
               64'({sh_stat_ack[ch], sh_stat_int[ch], sh_stat_rdata[ch]}));
      end
   endtask

   // --------------------
   // Reference model
   // --------------------

   task automatic model_reset();
      m_scrb_en   = '0;
      m_dbg_en    = 1'b0;
      m_dbg_sel   = 3'd0;
      m_flr_req_q = 1'b0;
      m_flr_done  = 1'b0;
      m_done      = '0;
      m_id0       = ID0_WORD;
      m_id1       = ID1_WORD;
      m_c_ready_q = 1'b0;
      for (int ch = 0; ch < 4; ch++)
      begin
         m_addr[ch] = '0;
         en_cnt[ch] = 0;
      end
      req_q.delete();
      ack_q.delete();
      repeat (STAT_STAGES)
      begin
         req_q.push_back('0);
         ack_q.push_back('0);
      end
   endtask

   // Called at each rising edge with the inputs the DUT samples there
   task automatic model_update();
      int           sel_ch;
      logic [125:0] req_word;
      logic [122:0] ack_word;
      case (m_dbg_sel)
         3'd3:    sel_ch = 3;
         3'd2:    sel_ch = 2;
         3'd1:    sel_ch = 1;
         default: sel_ch = 0;
      endcase
      // Readback sees the addresses before this edge moves them
      m_id0 = m_dbg_en ? m_addr[sel_ch][31:0] : ID0_WORD;
      m_id1 = m_dbg_en ? m_addr[sel_ch][63:32] : ID1_WORD;
      for (int ch = 0; ch < 4; ch++)
      begin
         if (m_scrb_en[ch] && !m_done[ch])
         begin
            en_cnt[ch]++;
            if (m_addr[ch] == LAST_BURST)
            begin
               m_done[ch] = 1'b1;
            end
            else
            begin
               m_addr[ch] = m_addr[ch] + BURST_BYTES;
            end
         end
      end
      m_flr_done  = m_flr_req_q && !m_flr_done;
      m_flr_req_q = flr_req;
      m_scrb_en   = ctl0[3:0];
      m_dbg_en    = ctl0[31];
      m_dbg_sel   = ctl0[30:28];
      m_c_ready_q = ddr_c_ready;
      for (int ch = 0; ch < 3; ch++)
      begin
         req_word[ch*42 +: 42] = {sh_stat_wr[ch], sh_stat_rd[ch], sh_stat_addr[ch],
                                  sh_stat_wdata[ch]};
         ack_word[ch*41 +: 41] = {ddr_stat_ack[ch], ddr_stat_int[ch], ddr_stat_rdata[ch]};
      end
      req_q.push_back(req_word);
      ack_q.push_back(ack_word);
      void'(req_q.pop_front());
      void'(ack_q.pop_front());
   endtask

   // --------------------
   // Stimulus
   // --------------------

   task automatic drive_inputs(input logic [31:0] ctl_word);
      ctl0 <= ctl_word;
      // Held or toggled at random
      if (rand_bits(1) != 0)
      begin
         flr_req <= ~flr_req;
      end
      ddr_ready   <= 3'(rand_bits(3));
      ddr_c_ready <= rand_bits(1) != 0;
      for (int ch = 0; ch < 3; ch++)
      begin
         sh_stat_wr[ch]     <= rand_bits(1) != 0;
         sh_stat_rd[ch]     <= rand_bits(1) != 0;
         sh_stat_addr[ch]   <= 8'(rand_bits(8));
         sh_stat_wdata[ch]  <= rand_bits(32);
         ddr_stat_ack[ch]   <= rand_bits(1) != 0;
         ddr_stat_int[ch]   <= 8'(rand_bits(8));
         ddr_stat_rdata[ch] <= rand_bits(32);
      end
   endtask

   task automatic tick(input logic [31:0] ctl_word);
      @(posedge clk);
      model_update();
      drive_inputs(ctl_word);
      @(negedge clk);
      check_outputs();
   endtask

   task automatic wait_scrub_done(input int ch);
      int cnt;
      cnt = 0;
      while (all_scrb_done[ch] !== 1'b1 && cnt < DONE_TIMEOUT)
      begin
         tick(scrub_ctl_word());
         cnt++;
      end
      if (all_scrb_done[ch] !== 1'b1)
      begin
         errors++;
         $display("Timeout while waiting for scrub done on channel %0d", ch);
      end
      else
      begin
         check($sformatf("scrub ch%0d enabled cycles", ch), 64'(ENABLED_CYCLES),
               64'(en_cnt[ch]));
      end
   endtask

   initial
   begin
      lfsr_state  = 16'd18;
      errors      = 0;
      checks      = 0;
      phase       = "reset";
      sync_rst_n  = 1'b0;
      ctl0        = '0;
      flr_req     = 1'b0;
      ddr_ready   = '0;
      ddr_c_ready = 1'b0;
      sh_stat_wr  = '0;
      sh_stat_rd  = '0;
      ddr_stat_ack = '0;
      for (int ch = 0; ch < 3; ch++)
      begin
         sh_stat_addr[ch]   = '0;
         sh_stat_wdata[ch]  = '0;
         ddr_stat_int[ch]   = '0;
         ddr_stat_rdata[ch] = '0;
      end
      model_reset();

      repeat (7) @(posedge clk);
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      sync_rst_n <= 1'b1;

      phase = "flr";
      repeat (40) tick(32'h0);

      phase = "scrub";
      for (int ch = 0; ch < 4; ch++)
      begin
         wait_scrub_done(ch);
      end

      phase = "debug";
      repeat (30) tick({1'b1, 3'(rand_bits(3)), 28'h0});

      // Debug off brings back the ID words and drains the pipes
      phase = "idle";
      repeat (12) tick(32'h0);

      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
